// File: logic/box_cfg_store.sv
// =========================================================================
// Per-box config store: 16-slot word memory with valid mask, hot-plug
// replay scanner and a small circular record FIFO
// =========================================================================
`default_nettype none

module box_cfg_store #(
    parameter int BOX_ID     = 0,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                     clk_12_5m,
    input  wire                     rst_n,
    input  wire cmm_pkg::box_cmd_t  cmd,
    output cmm_pkg::box_sts_t       sts,
    output cmm_pkg::cfg_rec_t       rec,
    output logic                    rec_valid,
    input  wire                     rec_pop
);
    import cmm_pkg::*;

    // Power of two, at least 2
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0]     mem [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  valid_mask;
    logic [NUM_SLOTS-1:0]  scan_mask;
    logic [SLOT_W-1:0]     scan_slot;
    scan_state_e           state;
    logic                  hit;
    logic                  full;
    logic                  push;
    logic                  advance;
    logic                  pop;
    cfg_rec_t              new_rec;
    cfg_rec_t              fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;

    // =====================================================================
    // Word memory and valid mask
    // =====================================================================
    always_ff @(posedge clk_12_5m)
    begin
        if (cmd.op == OP_CFG_WR)
            mem[cmd.slot] <= cmd.wdata;
    end

    // Sticky until reset
    always_ff @(posedge clk_12_5m or negedge rst_n)
    begin
        if (!rst_n)
            valid_mask <= '0;
        else if (cmd.op == OP_CFG_WR)
            valid_mask[cmd.slot] <= 1'b1;
    end

    assign sts = '{rdata: mem[cmd.slot], valid_mask: valid_mask,
                   busy: (state == ST_SCAN)};

    // =====================================================================
    // Replay scanner, one slot per cycle
    // =====================================================================
    assign hit     = scan_mask[scan_slot] && valid_mask[scan_slot];
    assign full    = (int'(count) == FIFO_DEPTH);
    // Stall on a hit while the FIFO has no room
    assign push    = (state == ST_SCAN) && hit && !full;
    assign advance = (state == ST_SCAN) && !(hit && full);

    always_ff @(posedge clk_12_5m)
    begin
        if (cmd.op == OP_CTL_WR)
            scan_mask <= cmd.wdata[NUM_SLOTS-1:0];
    end

    always_ff @(posedge clk_12_5m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            scan_slot <= '0;
        end
        else if (cmd.op == OP_CTL_WR)
        begin
            state     <= ST_SCAN;
            scan_slot <= '0;
        end
        else if (advance)
        begin
            // Last slot handled, busy drops next cycle
            if (scan_slot == '1)
                state <= ST_IDLE;
            scan_slot <= scan_slot + 1'b1;
        end
    end

    // =====================================================================
    // Record FIFO
    // =====================================================================
    assign new_rec = '{box: BOX_W'(BOX_ID), slot: scan_slot, data: mem[scan_slot]};
    assign pop     = rec_pop && rec_valid;

    always_ff @(posedge clk_12_5m)
    begin
        if (push)
            fifo_mem[wr_ptr] <= new_rec;
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk_12_5m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign rec       = fifo_mem[rd_ptr];
    assign rec_valid = (count != '0);

endmodule

`default_nettype wire

// File: logic/cmm_apb_decoder.sv
// =========================================================================
// APB slave for the config memory manager: address decode into per-box
// commands, read data select, error flagging for bad addresses and
// writes to a busy box
// =========================================================================
`default_nettype none

module cmm_apb_decoder #(
    parameter int NUM_BOXES = 4
) (
    input  wire                          clk_12_5m,
    input  wire                          rst_n,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [cmm_pkg::APB_AW-1:0]    paddr,
    input  wire [cmm_pkg::APB_DW-1:0]    pwdata,
    output logic [cmm_pkg::APB_DW-1:0]   prdata,
    output logic                         pready,
    output logic                         pslverr,
    output cmm_pkg::box_cmd_t            cmd [NUM_BOXES],
    input  wire cmm_pkg::box_sts_t       sts [NUM_BOXES]
);
    import cmm_pkg::*;

    // Control words live at 0x100 + 4*box
    localparam logic [7:0] CTL_ADDR_HI = 8'h10;

    logic                  setup;
    logic                  access;
    logic                  is_cfg;
    logic                  is_ctl;
    logic [BOX_W-1:0]      box;
    logic [SLOT_W-1:0]     slot;
    logic                  box_ok;
    cmd_op_e               op;
    box_sts_t              sel_sts;
    logic                  err;
    logic [APB_DW-1:0]     rdata;
    logic                  err_q;
    logic [APB_DW-1:0]     prdata_q;

    // =====================================================================
    // Address classification
    // =====================================================================
    assign setup  = psel && !penable;
    assign access = psel && penable;

    // Config words fill 0x000..0x0FF
    assign is_cfg = (paddr[11:8] == 4'h0);
    assign is_ctl = (paddr[11:4] == CTL_ADDR_HI);
    assign box    = is_ctl ? paddr[3:2] : paddr[7:6];
    assign slot   = paddr[5:2];
    assign box_ok = (int'(box) < NUM_BOXES);

    always_comb
    begin
        if (is_cfg)
            op = pwrite ? OP_CFG_WR : OP_CFG_RD;
        else if (is_ctl)
            op = pwrite ? OP_CTL_WR : OP_CTL_RD;
        else
            op = OP_NONE;
    end

    // Status of the addressed box, zero when out of range
    always_comb
    begin
        sel_sts = '0;
        for (int i = 0; i < NUM_BOXES; i++)
        begin
            if (int'(box) == i)
                sel_sts = sts[i];
        end
    end

    // Unmapped, missing box, or write while a replay runs
    assign err = (op == OP_NONE) || !box_ok || (pwrite && sel_sts.busy);

    // Read data, word or {busy, valid_mask}
    always_comb
    begin
        rdata = '0;
        if (!err && !pwrite)
        begin
            if (is_cfg)
                rdata[DATA_W-1:0] = sel_sts.rdata;
            else
            begin
                rdata[NUM_SLOTS]     = sel_sts.busy;
                rdata[NUM_SLOTS-1:0] = sel_sts.valid_mask;
            end
        end
    end

    // =====================================================================
    // Response registers, loaded in setup, held through access
    // =====================================================================
    always_ff @(posedge clk_12_5m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            err_q    <= 1'b0;
            prdata_q <= '0;
        end
        else if (setup)
        begin
            err_q    <= err;
            prdata_q <= rdata;
        end
        else if (access)
        begin
            // Back to idle response after the access phase
            err_q    <= 1'b0;
            prdata_q <= '0;
        end
    end

    assign pready  = 1'b1;
    assign pslverr = err_q;
    assign prdata  = prdata_q;

    // One-box command, only in an error-free access phase
    always_comb
    begin
        for (int i = 0; i < NUM_BOXES; i++)
        begin
            cmd[i].op    = (access && !err_q && int'(box) == i) ? op : OP_NONE;
            cmd[i].slot  = slot;
            cmd[i].wdata = pwdata[DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/cmm_pkg.sv
// =========================================================================
// Shared widths, per-box command and status structs, output record
// struct, operation and scanner state enums
// =========================================================================
`default_nettype none

package cmm_pkg;

    // =====================================================================
    // Widths
    // =====================================================================
    // One configuration word
    localparam int DATA_W    = 18;
    // Slot index, 16 slots per box
    localparam int SLOT_W    = 4;
    localparam int NUM_SLOTS = 1 << SLOT_W;
    // Box index, up to four boxes
    localparam int BOX_W     = 2;
    // APB bus widths
    localparam int APB_AW    = 12;
    localparam int APB_DW    = 32;

    // =====================================================================
    // Enums
    // =====================================================================
    // Per-box operation from the APB decoder
    typedef enum logic [2:0] {
        OP_NONE,
        OP_CFG_WR,
        OP_CFG_RD,
        OP_CTL_WR,
        OP_CTL_RD
    } cmd_op_e;

    // Replay scanner
    typedef enum logic {
        ST_IDLE,
        ST_SCAN
    } scan_state_e;

    // =====================================================================
    // Structs
    // =====================================================================
    // Decoder to store, wdata[15:0] is the slot mask on OP_CTL_WR
    typedef struct packed {
        cmd_op_e               op;
        logic [SLOT_W-1:0]     slot;
        logic [DATA_W-1:0]     wdata;
    } box_cmd_t;

    // Store to decoder
    typedef struct packed {
        logic [DATA_W-1:0]     rdata;
        logic [NUM_SLOTS-1:0]  valid_mask;
        logic                  busy;
    } box_sts_t;

    // One replayed word on the output stream, 24 bits
    typedef struct packed {
        logic [BOX_W-1:0]      box;
        logic [SLOT_W-1:0]     slot;
        logic [DATA_W-1:0]     data;
    } cfg_rec_t;

endpackage

`default_nettype wire

// File: logic/cmm_read_merger.sv
// =========================================================================
// Round-robin drain of the per-box record FIFOs into one registered
// valid/ready output stream
// =========================================================================
`default_nettype none

module cmm_read_merger #(
    parameter int NUM_BOXES = 4
) (
    input  wire                          clk_12_5m,
    input  wire                          rst_n,
    input  wire cmm_pkg::cfg_rec_t       rec [NUM_BOXES],
    input  wire [NUM_BOXES-1:0]          rec_valid,
    output logic [NUM_BOXES-1:0]         rec_pop,
    output cmm_pkg::cfg_rec_t            out_rec,
    output logic                         out_valid,
    input  wire                          out_ready
);
    import cmm_pkg::*;

    logic                  load_en;
    logic                  found;
    logic [BOX_W-1:0]      pick;
    logic [BOX_W-1:0]      last_q;

    // Output register empty or draining this cycle
    assign load_en = !out_valid || out_ready;

    // =====================================================================
    // Rotating priority, search starts after the last box served
    // =====================================================================
    always_comb
    begin
        int idx;
        found = 1'b0;
        pick  = '0;
        for (int k = 1; k <= NUM_BOXES; k++)
        begin
            idx = (int'(last_q) + k) % NUM_BOXES;
            if (!found && rec_valid[idx])
            begin
                found = 1'b1;
                pick  = BOX_W'(idx);
            end
        end
    end

    // One-cycle pop of the granted FIFO head
    always_comb
    begin
        rec_pop = '0;
        if (load_en && found)
            rec_pop[pick] = 1'b1;
    end

    // =====================================================================
    // Output stage
    // =====================================================================
    always_ff @(posedge clk_12_5m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            // Box 0 gets first turn
            last_q    <= BOX_W'(NUM_BOXES - 1);
        end
        else if (load_en)
        begin
            out_valid <= found;
            if (found)
                last_q <= pick;
        end
    end

    // Held while stalled
    always_ff @(posedge clk_12_5m)
    begin
        if (load_en && found)
            out_rec <= rec[pick];
    end

endmodule

`default_nettype wire

// File: logic/ex_cmm_top.sv
// =========================================================================
// Config memory manager top: APB decoder, one store per extension box,
// record merger onto the output stream
// =========================================================================
`default_nettype none

module ex_cmm_top #(
    parameter int NUM_BOXES  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                          clk_12_5m,
    input  wire                          rst_n,
    // APB slave
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [cmm_pkg::APB_AW-1:0]    paddr,
    input  wire [cmm_pkg::APB_DW-1:0]    pwdata,
    output wire [cmm_pkg::APB_DW-1:0]    prdata,
    output wire                          pready,
    output wire                          pslverr,
    // Replay record stream
    output wire cmm_pkg::cfg_rec_t       out_rec,
    output wire                          out_valid,
    input  wire                          out_ready
);
    import cmm_pkg::*;

    wire box_cmd_t         cmd [NUM_BOXES];
    wire box_sts_t         sts [NUM_BOXES];
    wire cfg_rec_t         rec [NUM_BOXES];
    wire [NUM_BOXES-1:0]   rec_valid;
    wire [NUM_BOXES-1:0]   rec_pop;

    // =====================================================================
    // Host access
    // =====================================================================
    cmm_apb_decoder #(
        .NUM_BOXES  (NUM_BOXES)
    ) u_cmm_apb_decoder (
        .clk_12_5m  (clk_12_5m),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cmd        (cmd),
        .sts        (sts)
    );

    // =====================================================================
    // Box stores, box number stamped into each record
    // =====================================================================
    for (genvar i = 0; i < NUM_BOXES; i++)
    begin : g_box
        box_cfg_store #(
            .BOX_ID     (i),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_box_cfg_store (
            .clk_12_5m  (clk_12_5m),
            .rst_n      (rst_n),
            .cmd        (cmd[i]),
            .sts        (sts[i]),
            .rec        (rec[i]),
            .rec_valid  (rec_valid[i]),
            .rec_pop    (rec_pop[i])
        );
    end

    // Single output stream
    cmm_read_merger #(
        .NUM_BOXES  (NUM_BOXES)
    ) u_cmm_read_merger (
        .clk_12_5m  (clk_12_5m),
        .rst_n      (rst_n),
        .rec        (rec),
        .rec_valid  (rec_valid),
        .rec_pop    (rec_pop),
        .out_rec    (out_rec),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_cmm \
    -f vlog.f -o tb_ex_cmm \
    && ./obj_dir/tb_ex_cmm > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// File: tests/tb_ex_cmm.sv
// ==========================================================================
// Testbench for the config memory manager with clock and reset, APB
// driver tasks, reference model, record monitor and directed tests
// ==========================================================================
`default_nettype none

module tb_ex_cmm;
    import cmm_pkg::*;

    localparam int NUM_BOXES  = 4;
    localparam int FIFO_DEPTH = 4;
    // Cycle and poll limits for every wait loop
    localparam int MAX_CYCLES = 4000;
    localparam int MAX_POLLS  = 200;

    logic                  clk_12_5m;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_AW-1:0]     paddr;
    logic [APB_DW-1:0]     pwdata;
    wire  [APB_DW-1:0]     prdata;
    wire                   pready;
    wire                   pslverr;
    wire  cfg_rec_t        out_rec;
    wire                   out_valid;
    logic                  out_ready;

    // Reference model written only by accepted config writes
    logic [DATA_W-1:0]     model_mem [NUM_BOXES][NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  model_valid [NUM_BOXES];
    // Mask of the replay under test or zero when not replaying
    logic [NUM_SLOTS-1:0]  replay_mask [NUM_BOXES];
    cfg_rec_t              got_q [$];

    string                 cur_test;
    int                    test_errors;
    int                    passed_tests;
    int                    failed_tests;
    int unsigned           seed_val;

    ex_cmm_top #(
        .NUM_BOXES  (NUM_BOXES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ex_cmm_top (
        .clk_12_5m  (clk_12_5m),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .out_rec    (out_rec),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    initial
    begin
        clk_12_5m = 1'b0;
        forever #2 clk_12_5m = ~clk_12_5m;
    end

    // Record monitor with one entry per transfer
    always @(posedge clk_12_5m)
    begin
        if (rst_n && out_valid && out_ready)
            got_q.push_back(out_rec);
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [APB_AW-1:0] cfg_addr(input int b, input int s);
        return APB_AW'((b << 6) | (s << 2));
    endfunction

    function automatic logic [APB_AW-1:0] ctl_addr(input int b);
        return APB_AW'(256 + (b << 2));
    endfunction

    // Slots in mask AND valid over all boxes
    function automatic int expected_count();
        int n;
        n = 0;
        for (int b = 0; b < NUM_BOXES; b++)
            for (int s = 0; s < NUM_SLOTS; s++)
                if (replay_mask[b][s] && model_valid[b][s])
                    n++;
        return n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0)
        begin
            $display("%s: passed", cur_test);
            passed_tests++;
        end
        else
        begin
            $display("%s: failed with %0d errors", cur_test, test_errors);
            failed_tests++;
        end
    endtask

    // ======================================================================
    // APB driver with a setup phase then an access phase
    // ======================================================================
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
        @(posedge clk_12_5m);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk_12_5m);
        #1;
        penable = 1'b1;
        // No wait states so the response is sampled in the first access cycle
        check_value("pready in access", 32'd1, 32'(pready));
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_12_5m);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] wdata,
                             output logic [APB_DW-1:0] rdata, output logic err);
        apb_xfer(1'b1, addr, wdata, rdata, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr,
                            output logic [APB_DW-1:0] rdata, output logic err);
        apb_xfer(1'b0, addr, '0, rdata, err);
    endtask

    // Config write that updates the model only when no error is expected
    task automatic write_word(input int b, input int s, input logic [APB_DW-1:0] wdata,
                              input logic exp_err);
        logic [APB_DW-1:0] rdata;
        logic err;
        apb_write(cfg_addr(b, s), wdata, rdata, err);
        check_value($sformatf("pslverr on write box %0d slot %0d", b, s), 32'(exp_err),
                    32'(err));
        if (!exp_err)
        begin
            model_mem[b][s]   = wdata[DATA_W-1:0];
            model_valid[b][s] = 1'b1;
        end
    endtask

    task automatic start_replay(input int b, input logic [NUM_SLOTS-1:0] mask);
        logic [APB_DW-1:0] rdata;
        logic err;
        replay_mask[b] = mask;
        apb_write(ctl_addr(b), APB_DW'(mask), rdata, err);
        check_value($sformatf("pslverr on replay box %0d", b), 32'd0, 32'(err));
    endtask

    // Written words and control status of every box against the model
    task automatic verify_all();
        logic [APB_DW-1:0] rdata;
        logic err;
        for (int b = 0; b < NUM_BOXES; b++)
        begin
            for (int s = 0; s < NUM_SLOTS; s++)
            begin
                if (model_valid[b][s])
                begin
                    apb_read(cfg_addr(b, s), rdata, err);
                    check_value($sformatf("word box %0d slot %0d", b, s),
                                APB_DW'(model_mem[b][s]), rdata);
                    check_value("pslverr on word read", 32'd0, 32'(err));
                end
            end
            apb_read(ctl_addr(b), rdata, err);
            check_value($sformatf("control box %0d", b), APB_DW'(model_valid[b]), rdata);
            check_value("pslverr on control read", 32'd0, 32'(err));
        end
    endtask

    // Optionally toggles out_ready at random while waiting
    task automatic wait_records(input int n, input bit random_ready);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < MAX_CYCLES)
        begin
            @(posedge clk_12_5m);
            #1;
            if (random_ready)
                out_ready = 1'($urandom % 2);
            waited++;
        end
        out_ready = 1'b1;
        if (got_q.size() < n)
        begin
            $display("Timeout in %s: only %0d of %0d records arrived", cur_test,
                     got_q.size(), n);
            test_errors++;
        end
    endtask

    task automatic wait_idle(input int b);
        logic [APB_DW-1:0] rdata;
        logic err;
        int polls;
        polls = 0;
        rdata = 32'h0001_0000;
        while (rdata[NUM_SLOTS] && polls < MAX_POLLS)
        begin
            apb_read(ctl_addr(b), rdata, err);
            polls++;
        end
        if (rdata[NUM_SLOTS])
        begin
            $display("Timeout in %s: box %0d still busy", cur_test, b);
            test_errors++;
        end
    endtask

    // Per-box order and content of the collected records
    task automatic check_records();
        cfg_rec_t exp_q [$];
        cfg_rec_t act_q [$];
        cfg_rec_t exp_rec;
        int total;
        total = 0;
        for (int b = 0; b < NUM_BOXES; b++)
        begin
            exp_q.delete();
            act_q.delete();
            for (int s = 0; s < NUM_SLOTS; s++)
            begin
                if (replay_mask[b][s] && model_valid[b][s])
                begin
                    exp_rec = '{box: BOX_W'(b), slot: SLOT_W'(s), data: model_mem[b][s]};
                    exp_q.push_back(exp_rec);
                end
            end
            foreach (got_q[i])
                if (int'(got_q[i].box) == b)
                    act_q.push_back(got_q[i]);
            check_value($sformatf("box %0d record count", b), 32'(exp_q.size()),
                        32'(act_q.size()));
            for (int i = 0; i < exp_q.size() && i < act_q.size(); i++)
                check_value($sformatf("box %0d record %0d", b, i), 32'(exp_q[i]),
                            32'(act_q[i]));
            total += exp_q.size();
        end
        check_value("total records", 32'(total), 32'(got_q.size()));
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset_state();
        start_test("reset_state");
        check_value("out_valid", 32'd0, 32'(out_valid));
        verify_all();
        end_test();
    endtask

    // Slots 12..15 stay unwritten for the replay tests
    task automatic test_cfg_readback();
        start_test("cfg_readback");
        for (int i = 0; i < 32; i++)
            write_word($urandom % NUM_BOXES, $urandom % 12, $urandom, 1'b0);
        verify_all();
        end_test();
    endtask

    task automatic test_unmapped();
        logic [APB_AW-1:0] bad_addr [3];
        logic [APB_DW-1:0] rdata;
        logic err;
        start_test("unmapped");
        // Gap above the control words plus bit 8 and high space beyond them
        bad_addr = '{12'h110, 12'h180, 12'h7fc};
        foreach (bad_addr[i])
        begin
            apb_write(bad_addr[i], $urandom, rdata, err);
            check_value($sformatf("pslverr on write %h", bad_addr[i]), 32'd1, 32'(err));
            apb_read(bad_addr[i], rdata, err);
            check_value($sformatf("pslverr on read %h", bad_addr[i]), 32'd1, 32'(err));
            check_value($sformatf("prdata on read %h", bad_addr[i]), 32'd0, rdata);
        end
        verify_all();
        end_test();
    endtask

    task automatic test_single_replay();
        start_test("single_replay");
        write_word(0, 0, $urandom, 1'b0);
        write_word(0, 2, $urandom, 1'b0);
        foreach (replay_mask[b])
            replay_mask[b] = '0;
        got_q.delete();
        out_ready = 1'b1;
        // Valid low slots plus unwritten 12..15
        start_replay(0, 16'hf0f5);
        wait_records(expected_count(), 1'b0);
        wait_idle(0);
        check_records();
        end_test();
    endtask

    task automatic test_backpressure();
        logic [APB_DW-1:0] rdata;
        logic err;
        start_test("backpressure");
        for (int s = 0; s < 8; s++)
            write_word(1, s, $urandom, 1'b0);
        foreach (replay_mask[b])
            replay_mask[b] = '0;
        got_q.delete();
        out_ready = 1'b0;
        start_replay(1, 16'hffff);
        // Scanner stalls with the FIFO full
        apb_read(ctl_addr(1), rdata, err);
        check_value("busy while stalled", 32'd1, 32'(rdata[NUM_SLOTS]));
        write_word(1, 3, $urandom, 1'b1);
        for (int b = 0; b < NUM_BOXES; b++)
            if (b != 1)
                start_replay(b, 16'($urandom));
        wait_records(expected_count(), 1'b1);
        for (int b = 0; b < NUM_BOXES; b++)
            wait_idle(b);
        check_records();
        // Rejected write left slot 3 intact
        verify_all();
        end_test();
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial
    begin
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        out_ready    = 1'b0;
        passed_tests = 0;
        failed_tests = 0;
        seed_val     = $urandom(94569);
        foreach (model_valid[b])
            model_valid[b] = '0;
        repeat (3) @(posedge clk_12_5m);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_cfg_readback();
        test_unmapped();
        test_single_replay();
        test_backpressure();

        $display("Tests run %0d, passed %0d, failed %0d", passed_tests + failed_tests,
                 passed_tests, failed_tests);
        if (failed_tests == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/cmm_pkg.sv
logic/cmm_apb_decoder.sv
logic/box_cfg_store.sv
logic/cmm_read_merger.sv
logic/ex_cmm_top.sv
tests/tb_ex_cmm.sv
